//--- sim.f
logic/debug_pkg.sv
logic/host_link_if.sv
logic/debug_sequencer.sv
logic/program_loader.sv
logic/report_sender.sv
logic/debug_unit.sv
test/tb_clock_gen.sv
test/tb_debug_unit.sv

//--- Bender.yml
package:
  name: debug_unit

sources:
  - logic/debug_pkg.sv
  - logic/host_link_if.sv
  - logic/debug_sequencer.sv
  - logic/program_loader.sv
  - logic/report_sender.sv
  - logic/debug_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_debug_unit.sv

//--- test/tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_unit;
  import debug_pkg::*;

  localparam int addr_width  = 11;
  localparam int prog1_words = 5;
  localparam int prog2_words = 2;
  localparam int wrong_reqs  = 3;
  // Each session sends open, ack, start and ten requests. Each program ends with a zero word.
  localparam int bytes_total     = 2 * 13 + 4 * (prog1_words + prog2_words + 2) + wrong_reqs;
  localparam int watchdog_cycles = bytes_total * 10 + 200;

  logic                  clock;
  logic                  reset;
  logic                  rx_done;
  logic [7:0]            rx_byte;
  logic                  tx_done;
  logic                  soft_reset_ack;
  logic [31:0]           fetch_instr;
  logic [31:0]           debug_data;
  logic                  tx_start;
  logic [7:0]            tx_data;
  logic                  soft_reset;
  logic                  mem_write;
  logic [addr_width-1:0] mem_addr;
  logic [31:0]           mem_data;
  logic                  exec_mode;
  logic                  enable_pc;
  dbg_select_e           debug_select;

  int errors;
  int write_count;
  int tests_run;
  int tests_failed;
  int test_errors_start;

  tb_clock_gen clock_gen_i (
    .o_clock (clock),
    .o_reset (reset)
  );

  debug_unit #(
    .addr_width (addr_width)
  ) dut_i (
    .i_clock          (clock),
    .i_reset          (reset),
    .i_rx_done        (rx_done),
    .i_rx_byte        (rx_byte),
    .i_tx_done        (tx_done),
    .i_soft_reset_ack (soft_reset_ack),
    .i_fetch_instr    (fetch_instr),
    .i_debug_data     (debug_data),
    .o_tx_start       (tx_start),
    .o_tx_data        (tx_data),
    .o_soft_reset     (soft_reset),
    .o_mem_write      (mem_write),
    .o_mem_addr       (mem_addr),
    .o_mem_data       (mem_data),
    .o_exec_mode      (exec_mode),
    .o_enable_pc      (enable_pc),
    .o_debug_select   (debug_select)
  );

  //////////////////////////////
  // Protocol assertions
  //////////////////////////////

  a_write_nonzero: assert property (@(posedge clock) disable iff (!reset)
      mem_write |-> mem_data != '0) else begin
    errors++;
    $display("** Error at %0t: o_mem_data expected non-zero, got %h", $time, $sampled(mem_data));
  end

  a_write_pulse: assert property (@(posedge clock) disable iff (!reset)
      mem_write |=> !mem_write) else begin
    errors++;
    $display("** Error at %0t: o_mem_write expected 0 after a pulse, got 1", $time);
  end

  a_halt_stops: assert property (@(posedge clock) disable iff (!reset)
      (enable_pc && fetch_instr == halt_instr) |=> !enable_pc) else begin
    errors++;
    $display("** Error at %0t: o_enable_pc expected 0 after halt, got 1", $time);
  end

  a_quiet_in_reset: assert property (@(posedge clock) disable iff (!reset)
      !soft_reset |-> (!enable_pc && !tx_start)) else begin
    errors++;
    $display("** Error at %0t: o_enable_pc/o_tx_start expected 0/0 in soft reset, got %b/%b",
             $time, $sampled(enable_pc), $sampled(tx_start));
  end

  always @(negedge clock) begin
    if (reset && mem_write) begin
      write_count++; // Every write seen on the memory port.
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - test_errors_start);
    end
    test_errors_start = errors;
  endtask

  function automatic logic [31:0] nonzero_word();
    logic [31:0] w;
    w = $urandom;
    while (w == '0) begin
      w = $urandom;
    end
    return w;
  endfunction

  function automatic dbg_select_e report_source(input int k);
    case (k / 2)
      0: return sel_pc;
      1: return sel_cycles;
      2: return sel_pc_plus4;
      default: return sel_instr;
    endcase
  endfunction

  // High byte first in the pairs and the instruction from byte 3 down.
  function automatic int report_pos(input int k);
    return (k < 6) ? 1 - (k % 2) : 9 - k;
  endfunction

  function automatic bit event_seen(input bit pc_stop);
    return pc_stop ? !enable_pc : tx_start;
  endfunction

  task automatic wait_event(input bit pc_stop, input int limit);
    int n = 0;
    @(negedge clock);
    while (!event_seen(pc_stop) && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (!event_seen(pc_stop)) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %s", limit,
               pc_stop ? "o_enable_pc to fall" : "o_tx_start to rise");
    end
  endtask

  // Host UART model holding rx done high for three cycles.
  task automatic send_byte(input logic [7:0] value);
    @(posedge clock);
    rx_byte <= value;
    rx_done <= 1'b1;
    repeat (3) @(posedge clock);
    rx_done <= 1'b0;
    @(posedge clock); // Strobe taken here.
  endtask

  task automatic open_session();
    send_byte(cmd_session);
    repeat (4) begin
      @(negedge clock);
      check_value("o_soft_reset", 0, soft_reset);
    end
    @(posedge clock);
    soft_reset_ack <= 1'b0; // Core is in reset.
    wait_event(1'b0, 8);
    check_value("o_tx_data", cmd_ack, tx_data);
    check_value("o_soft_reset", 1, soft_reset);
    @(posedge clock);
    soft_reset_ack <= 1'b1;
    repeat (2) @(negedge clock);
    check_value("o_tx_start", 1, tx_start); // Ack held until the host answers.
    send_byte(cmd_ack);
    @(negedge clock);
    check_value("o_tx_start", 0, tx_start);
  endtask

  task automatic load_program(input int words);
    logic [31:0] word;
    int          writes_before;
    writes_before = write_count;
    for (int i = 0; i <= words; i++) begin
      word = (i == words) ? '0 : nonzero_word();
      for (int b = 3; b >= 0; b--) begin
        send_byte(word[b*8 +: 8]);
      end
      @(negedge clock);
      if (i < words) begin
        check_value("o_mem_write", 1, mem_write);
        check_value("o_mem_addr", i, mem_addr);
        check_value("o_mem_data", word, mem_data);
      end
    end
    repeat (2) @(negedge clock);
    check_value("write count", words, write_count - writes_before);
  endtask

  task automatic start_run(input logic [7:0] cmd, input logic mode);
    @(posedge clock);
    fetch_instr <= nonzero_word();
    send_byte(cmd);
    @(negedge clock);
    check_value("o_enable_pc", 1, enable_pc);
    check_value("o_exec_mode", mode, exec_mode);
    repeat (3) @(negedge clock);
    check_value("o_enable_pc", 1, enable_pc);
  endtask

  task automatic halt_and_report(input bit with_wrong);
    logic [31:0] data;
    logic [7:0]  wrong;
    int          pos;
    @(posedge clock);
    fetch_instr <= halt_instr;
    wait_event(1'b1, 4);
    for (int k = 0; k < 10; k++) begin
      @(posedge clock);
      data = $urandom;
      debug_data <= data;
      pos = report_pos(k);
      @(negedge clock);
      check_value("o_tx_start", 1, tx_start);
      check_value("o_debug_select", report_source(k), debug_select);
      check_value("o_tx_data", data[pos*8 +: 8], tx_data);
      if (with_wrong && (k == 0 || k == 4 || k == 9)) begin
        wrong = (k == 9) ? 8'h48 : 8'((k + 2) * 8); // Early or repeated request.
        send_byte(wrong);
        @(negedge clock);
        check_value("o_debug_select", report_source(k), debug_select);
        check_value("o_tx_data", data[pos*8 +: 8], tx_data);
      end
      send_byte(8'((k + 1) * 8));
    end
    @(negedge clock);
    check_value("o_tx_start", 0, tx_start);
    check_value("o_debug_select", sel_none, debug_select);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h3e07));
    errors            = 0;
    write_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_errors_start = 0;
    rx_done           = 1'b0;
    rx_byte           = 8'h00;
    tx_done           = 1'b0;
    soft_reset_ack    = 1'b1;
    fetch_instr       = 32'h2402_0001; // Any non-halt word.
    debug_data        = '0;

    while (reset !== 1'b1) @(negedge clock);
    check_value("o_soft_reset", 1, soft_reset);
    check_value("o_mem_write", 0, mem_write);
    check_value("o_tx_start", 0, tx_start);
    check_value("o_enable_pc", 0, enable_pc);
    check_value("o_exec_mode", 0, exec_mode);
    check_value("o_debug_select", sel_none, debug_select);
    end_test("reset state");

    open_session();
    end_test("session open");
    load_program(prog1_words);
    end_test("program load");
    start_run(cmd_run_step, 1'b1);
    end_test("start in step mode");
    halt_and_report(1'b0);
    end_test("halt and report");

    open_session();
    load_program(prog2_words);
    start_run(cmd_run_cont, 1'b0);
    end_test("second session in continuous mode");
    halt_and_report(1'b1);
    end_test("wrong request ignored");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 8
) (
  output logic o_clock,
  output logic o_reset
);

  initial begin
    o_clock = 1'b0;
    forever #(period_ns / 2) o_clock = ~o_clock;
  end

  // Active low, released on a rising edge.
  initial begin
    o_reset = 1'b0;
    repeat (reset_cycles) @(posedge o_clock);
    o_reset <= 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit #(
  parameter int addr_width = 11
) (
  input  wire                                i_clock,
  input  wire                                i_reset,
  input  wire                                i_rx_done,
  input  wire [debug_pkg::byte_width-1:0]    i_rx_byte,
  input  wire                                i_tx_done,       // UART port set only.
  input  wire                                i_soft_reset_ack,
  input  wire [debug_pkg::instr_width-1:0]   i_fetch_instr,
  input  wire [debug_pkg::instr_width-1:0]   i_debug_data,
  output logic                               o_tx_start,
  output logic [debug_pkg::byte_width-1:0]   o_tx_data,
  output logic                               o_soft_reset,
  output logic                               o_mem_write,
  output logic [addr_width-1:0]              o_mem_addr,
  output logic [debug_pkg::instr_width-1:0]  o_mem_data,
  output logic                               o_exec_mode,
  output logic                               o_enable_pc,
  output debug_pkg::dbg_select_e             o_debug_select
);

  logic load_active;
  logic load_done;
  logic send_ack;
  logic report_active;
  logic report_done;

  host_link_if link_if (
    .i_clock (i_clock)
  );

  //////////////////////////////
  // Session control
  //////////////////////////////

  debug_sequencer sequencer_i (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_done        (i_rx_done),
    .i_rx_byte        (i_rx_byte),
    .i_soft_reset_ack (i_soft_reset_ack),
    .i_fetch_instr    (i_fetch_instr),
    .i_load_done      (load_done),
    .i_report_done    (report_done),
    .link             (link_if.seq),
    .o_load_active    (load_active),
    .o_send_ack       (send_ack),
    .o_report_active  (report_active),
    .o_soft_reset     (o_soft_reset),
    .o_enable_pc      (o_enable_pc),
    .o_exec_mode      (o_exec_mode)
  );

  program_loader #(
    .addr_width (addr_width)
  ) loader_i (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .link          (link_if.loader),
    .i_load_active (load_active),
    .o_load_done   (load_done),
    .o_mem_write   (o_mem_write),
    .o_mem_addr    (o_mem_addr),
    .o_mem_data    (o_mem_data)
  );

  report_sender sender_i (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .link            (link_if.sender),
    .i_send_ack      (send_ack),
    .i_report_active (report_active),
    .i_debug_data    (i_debug_data),
    .o_debug_select  (o_debug_select),
    .o_report_done   (report_done)
  );

  // Transmit side out to the UART.
  assign o_tx_start = link_if.tx_start;
  assign o_tx_data  = link_if.tx_byte;

endmodule

`default_nettype wire

//--- logic/report_sender.sv
`timescale 1ns/1ps
`default_nettype none

module report_sender (
  input  wire                                i_clock,
  input  wire                                i_reset,
  host_link_if.sender                        link,
  input  wire                                i_send_ack,
  input  wire                                i_report_active,
  input  wire [debug_pkg::instr_width-1:0]   i_debug_data,
  output debug_pkg::dbg_select_e             o_debug_select,
  output logic                               o_report_done
);
  import debug_pkg::*;

  localparam int report_count = 10;
  localparam int idx_width    = $clog2(report_count);
  localparam int pos_width    = $clog2(bytes_per_instr);

  logic [idx_width-1:0]  report_idx;
  logic [pos_width-1:0]  byte_pos;
  dbg_select_e           report_sel;
  logic [byte_width-1:0] expected_req;
  logic [byte_width-1:0] report_byte;
  logic                  req_match;
  logic                  last_req;

  //////////////////////////////
  // Report order
  //////////////////////////////

  // PC, cycles and PC+4 send high byte then low. The instruction goes 3 to 0.
  always_comb begin
    case (report_idx)
      0: begin
        report_sel = sel_pc;
        byte_pos   = pos_width'(1);
      end
      1: begin
        report_sel = sel_pc;
        byte_pos   = pos_width'(0);
      end
      2: begin
        report_sel = sel_cycles;
        byte_pos   = pos_width'(1);
      end
      3: begin
        report_sel = sel_cycles;
        byte_pos   = pos_width'(0);
      end
      4: begin
        report_sel = sel_pc_plus4;
        byte_pos   = pos_width'(1);
      end
      5: begin
        report_sel = sel_pc_plus4;
        byte_pos   = pos_width'(0);
      end
      6: begin
        report_sel = sel_instr;
        byte_pos   = pos_width'(3);
      end
      7: begin
        report_sel = sel_instr;
        byte_pos   = pos_width'(2);
      end
      8: begin
        report_sel = sel_instr;
        byte_pos   = pos_width'(1);
      end
      default: begin
        report_sel = sel_instr;
        byte_pos   = pos_width'(0);
      end
    endcase
  end

  assign report_byte  = i_debug_data[byte_pos*byte_width +: byte_width];

  // Request k is (k+1) * 0x08.
  assign expected_req = byte_width'((int'(report_idx) + 1) * int'(cmd_report_base));
  assign req_match    = link.rx_strobe && (link.rx_byte == expected_req);
  assign last_req     = (report_idx == idx_width'(report_count - 1));

  //////////////////////////////
  // Report index
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      report_idx <= '0;
    end else if (!i_report_active) begin
      report_idx <= '0;
    end else if (req_match) begin
      // Wrong bytes leave the index where it is.
      report_idx <= last_req ? '0 : report_idx + 1'b1;
    end
  end

  assign o_report_done  = i_report_active && req_match && last_req;
  assign o_debug_select = i_report_active ? report_sel : sel_none;

  // Ack and report never overlap and share one sender.
  assign link.tx_start = i_send_ack | i_report_active;
  assign link.tx_byte  = i_send_ack ? byte_width'(cmd_ack) : report_byte;

endmodule

`default_nettype wire

//--- logic/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader #(
  parameter int addr_width = 11
) (
  input  wire                                i_clock,
  input  wire                                i_reset,
  host_link_if.loader                        link,
  input  wire                                i_load_active,
  output logic                               o_load_done,
  output logic                               o_mem_write,
  output logic [addr_width-1:0]              o_mem_addr,
  output logic [debug_pkg::instr_width-1:0]  o_mem_data
);
  import debug_pkg::*;

  localparam int cnt_width = $clog2(bytes_per_instr);

  logic [cnt_width-1:0]   byte_cnt;
  logic [addr_width-1:0]  addr_q;
  logic [instr_width-1:0] word_q;
  logic [instr_width-1:0] next_word;
  logic                   last_byte;
  logic                   take_byte;

  // Big endian, first byte ends up on top.
  assign next_word = {word_q[instr_width-byte_width-1:0], link.rx_byte};
  assign last_byte = (byte_cnt == cnt_width'(bytes_per_instr - 1));
  assign take_byte = i_load_active && link.rx_strobe;

  //////////////////////////////
  // Word assembly
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (take_byte) begin
      word_q <= next_word;
    end
  end

  //////////////////////////////
  // Counters and write pulse
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_cnt    <= '0;
      addr_q      <= '0;
      o_mem_write <= 1'b0;
      o_load_done <= 1'b0;
    end else begin
      o_mem_write <= 1'b0;
      o_load_done <= 1'b0;
      if (!i_load_active) begin
        byte_cnt <= '0; // Fresh start next load.
        addr_q   <= '0;
      end else begin
        if (o_mem_write) begin
          addr_q <= addr_q + 1'b1; // Step after each write.
        end
        if (link.rx_strobe) begin
          if (last_byte) begin
            byte_cnt <= '0;
            // A zero word ends the program and is not stored.
            if (next_word == '0) begin
              o_load_done <= 1'b1;
            end else begin
              o_mem_write <= 1'b1;
            end
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
      end
    end
  end

  assign o_mem_addr = addr_q;
  assign o_mem_data = word_q; // Complete while the write pulse is high.

endmodule

`default_nettype wire

//--- logic/debug_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module debug_sequencer (
  input  wire                                i_clock,
  input  wire                                i_reset,
  input  wire                                i_rx_done,
  input  wire [debug_pkg::byte_width-1:0]    i_rx_byte,
  input  wire                                i_soft_reset_ack,
  input  wire [debug_pkg::instr_width-1:0]   i_fetch_instr,
  input  wire                                i_load_done,
  input  wire                                i_report_done,
  host_link_if.seq                           link,
  output logic                               o_load_active,
  output logic                               o_send_ack,
  output logic                               o_report_active,
  output logic                               o_soft_reset,
  output logic                               o_enable_pc,
  output logic                               o_exec_mode
);
  import debug_pkg::*;

  seq_state_e state;
  seq_state_e state_next;
  logic       rx_done_q;
  logic       rx_strobe;
  logic       is_start_cmd;

  //////////////////////////////
  // Receive strobe
  //////////////////////////////

  // Falling edge of rx done, byte still valid.
  assign rx_strobe      = rx_done_q & ~i_rx_done;
  assign link.rx_strobe = rx_strobe;
  assign link.rx_byte   = i_rx_byte;

  assign is_start_cmd = (i_rx_byte == cmd_run_cont) || (i_rx_byte == cmd_run_step);

  //////////////////////////////
  // Session FSM
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (rx_strobe && i_rx_byte == cmd_session) begin
          state_next = st_soft_reset;
        end
      end
      st_soft_reset: begin
        if (!i_soft_reset_ack) begin // Core is in reset.
          state_next = st_wait_ack;
        end
      end
      st_wait_ack: begin
        if (rx_strobe && i_rx_byte == cmd_ack) begin
          state_next = st_load;
        end
      end
      st_load: begin
        if (i_load_done) begin
          state_next = st_wait_start;
        end
      end
      st_wait_start: begin
        if (rx_strobe && is_start_cmd) begin
          state_next = st_run;
        end
      end
      st_run: begin
        if (i_fetch_instr == halt_instr) begin
          state_next = st_report;
        end
      end
      st_report: begin
        if (i_report_done) begin // Last request answered.
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state       <= st_idle;
      rx_done_q   <= 1'b0;
      o_exec_mode <= 1'b0; // Continuous.
    end else begin
      state     <= state_next;
      rx_done_q <= i_rx_done;
      if (state == st_wait_start && rx_strobe && is_start_cmd) begin
        o_exec_mode <= i_rx_byte[2]; // 1 is step mode.
      end
    end
  end

  // Outputs follow the state directly.
  assign o_soft_reset    = (state != st_soft_reset); // Active low.
  assign o_send_ack      = (state == st_wait_ack);
  assign o_load_active   = (state == st_load);
  assign o_enable_pc     = (state == st_run);
  assign o_report_active = (state == st_report);

endmodule

`default_nettype wire

//--- logic/host_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface host_link_if (
  input wire i_clock
);
  import debug_pkg::*;

  logic                  rx_strobe; // One cycle per received byte.
  logic [byte_width-1:0] rx_byte;   // Valid with rx_strobe.
  logic                  tx_start;  // Level, byte held while high.
  logic [byte_width-1:0] tx_byte;

  // The sequencer decodes the UART receive side.
  modport seq (
    input  i_clock,
    output rx_strobe,
    output rx_byte
  );

  modport loader (
    input i_clock,
    input rx_strobe,
    input rx_byte
  );

  modport sender (
    input  i_clock,
    input  rx_strobe,
    input  rx_byte,
    output tx_start,
    output tx_byte
  );

endinterface

`default_nettype wire

//--- logic/debug_pkg.sv
`default_nettype none

package debug_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int byte_width      = 8;                        // UART word.
  localparam int instr_width     = 32;                       // MIPS instruction.
  localparam int bytes_per_instr = instr_width / byte_width; // Bytes per program word.

  // Fetching this word stops the core.
  localparam logic [instr_width-1:0] halt_instr = '0;

  //////////////////////////////
  // Host commands
  //////////////////////////////

  // Report request k is (k+1) times cmd_report_base.
  typedef enum logic [byte_width-1:0] {
    cmd_session     = 8'h00, // Open a session.
    cmd_ack         = 8'h01, // Acknowledge byte, both ways.
    cmd_run_cont    = 8'h03, // Continuous run.
    cmd_run_step    = 8'h07, // Step mode.
    cmd_report_base = 8'h08  // First report request.
  } host_cmd_e;

  //////////////////////////////
  // Sequencer and report select
  //////////////////////////////

  typedef enum logic [2:0] {
    st_idle,
    st_soft_reset,
    st_wait_ack,
    st_load,
    st_wait_start,
    st_run,
    st_report
  } seq_state_e;

  typedef enum logic [2:0] {
    sel_none     = 3'd0,
    sel_run      = 3'd1,
    sel_pc       = 3'd2,
    sel_cycles   = 3'd3,
    sel_pc_plus4 = 3'd4,
    sel_instr    = 3'd5
  } dbg_select_e;

endpackage

`default_nettype wire
